// File: Bender.yml
package:
  name: periph_soc

sources:
  - include_dirs:
      - include
    files:
      - design/periphPkg.sv
      - design/syncFifo.sv
      - design/apbDecoder.sv
      - design/gpioPort.sv
      - design/uartCore.sv
      - design/periphSoc.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/periphSoc_chk.sv
      - tb/periphSoc_tb.sv

// File: design/apbDecoder.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module apbDecoder (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  periphPkg::apbAddrT           paddr,
    input  periphPkg::apbDataT           pwdata,
    input  periphPkg::apbDataT           gpioRdata,
    input  periphPkg::apbDataT           uartRdata,
    input  logic                         gpioErr,
    input  logic                         uartErr,
    output periphPkg::apbDataT           prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         gpioSel,
    output logic                         uartSel,
    output logic                         regWrite,
    output logic [`PERIPH_OFFSET_W-1:0]  regAddr,
    output periphPkg::apbDataT           regWdata
);
    import periphPkg::*;

    localparam apbAddrT gpioBase = `GPIO_BASE;
    localparam apbAddrT uartBase = `UART_BASE;

    periphSelT regionSel;
    periphSelT regionQ;
    logic      readyQ;
    logic      setupPhase;

    // Setup cycle of a transfer
    assign setupPhase = psel & ~penable;

    // Region from the bits above the register offset
    always_comb begin
        if (paddr[`PERIPH_ADDR_W-1:`PERIPH_OFFSET_W] ==
            gpioBase[`PERIPH_ADDR_W-1:`PERIPH_OFFSET_W]) begin
            regionSel = selGpio;
        end else if (paddr[`PERIPH_ADDR_W-1:`PERIPH_OFFSET_W] ==
                     uartBase[`PERIPH_ADDR_W-1:`PERIPH_OFFSET_W]) begin
            regionSel = selUart;
        end else begin
            regionSel = selNone;
        end
    end

    // Completion is armed by the setup cycle
    // Access cycle then finishes on its first clock
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readyQ  <= 1'b0;
            regionQ <= selNone;
        end else begin
            readyQ <= setupPhase;
            if (setupPhase) begin
                regionQ <= regionSel;
            end
        end
    end

    assign pready = readyQ;

    // Strobes only in the completing cycle
    assign gpioSel = readyQ & (regionQ == selGpio);
    assign uartSel = readyQ & (regionQ == selUart);

    // Shared register bus toward both blocks
    assign regWrite = pwrite;
    assign regAddr  = paddr[`PERIPH_OFFSET_W-1:0];
    assign regWdata = pwdata;

    // Response merge
    // Unmapped region answers with an error and zero data
    always_comb begin
        case (regionQ)
            selGpio: begin
                prdata  = gpioRdata;
                pslverr = readyQ & gpioErr;
            end
            selUart: begin
                prdata  = uartRdata;
                pslverr = readyQ & uartErr;
            end
            default: begin
                prdata  = '0;
                pslverr = readyQ;
            end
        endcase
    end

endmodule

// File: design/gpioPort.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module gpioPort (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         sel,
    input  logic                         write,
    input  logic [`PERIPH_OFFSET_W-1:0]  addr,
    input  periphPkg::apbDataT           wdata,
    input  logic [`GPIO_W-1:0]           sw,
    input  logic [`GPIO_W-1:0]           gpioC,
    output periphPkg::apbDataT           rdata,
    output logic                         err,
    output logic [`GPIO_W-1:0]           led
);
    import periphPkg::*;

    logic [`GPIO_W-1:0] swMeta;
    logic [`GPIO_W-1:0] swSync;
    logic [`GPIO_W-1:0] cMeta;
    logic [`GPIO_W-1:0] cSync;
    logic [`GPIO_W-1:0] cPrev;
    logic [`GPIO_W-1:0] cRise;
    logic [`GPIO_W-1:0] edgeQ;
    logic [`GPIO_W-1:0] edgeClr;
    logic               ledWrite;
    logic               edgeWrite;

    // Two-flop synchronizers on both input ports
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            swMeta <= '0;
            swSync <= '0;
            cMeta  <= '0;
            cSync  <= '0;
            cPrev  <= '0;
        end else begin
            swMeta <= sw;
            swSync <= swMeta;
            cMeta  <= gpioC;
            cSync  <= cMeta;
            // Delayed copy for edge detection
            cPrev  <= cSync;
        end
    end

    // Rising edges seen on the synchronized port C
    assign cRise = cSync & ~cPrev;

    // Write strobes
    assign ledWrite  = sel & write & (addr == `GPIO_DATA_A);
    assign edgeWrite = sel & write & (addr == `GPIO_EDGE_C);
    assign edgeClr   = edgeWrite ? wdata[`GPIO_W-1:0] : '0;

    // LED output register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            led <= `GPIO_LED_RESET;
        end else if (ledWrite) begin
            led <= wdata[`GPIO_W-1:0];
        end
    end

    // Sticky edge bits
    // A new edge wins over a clear in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            edgeQ <= '0;
        end else begin
            edgeQ <= (edgeQ & ~edgeClr) | cRise;
        end
    end

    // Read mux and error decode
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (addr)
            `GPIO_DATA_A: rdata[`GPIO_W-1:0] = led;
            `GPIO_IN_B: begin
                rdata[`GPIO_W-1:0] = swSync;
                // Input port is read-only
                err = write;
            end
            `GPIO_IN_C: begin
                rdata[`GPIO_W-1:0] = cSync;
                err = write;
            end
            `GPIO_EDGE_C: rdata[`GPIO_W-1:0] = edgeQ;
            default: err = 1'b1;
        endcase
    end

endmodule

// File: design/periphPkg.sv
`include "periph_defs.svh"

package periphPkg;

    // One APB address word
    typedef logic [`PERIPH_ADDR_W-1:0] apbAddrT;

    // One APB data word
    typedef logic [`PERIPH_DATA_W-1:0] apbDataT;

    // Region chosen by the upper address bits
    typedef enum logic [1:0] {
        selNone,
        selGpio,
        selUart
    } periphSelT;

    // Raw serial byte
    typedef logic [7:0] uartByteT;

    // Received byte with its framing flag
    // Framing flag lands in bit 8
    typedef struct packed {
        logic     frameErr;
        uartByteT data;
    } rxEntryT;

endpackage

// File: design/periphSoc.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module periphSoc (
    input  logic                clk,
    input  logic                arstN,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  periphPkg::apbAddrT  paddr,
    input  periphPkg::apbDataT  pwdata,
    input  logic [`GPIO_W-1:0]  sw,
    input  logic [`GPIO_W-1:0]  gpioC,
    input  logic                uartRx,
    output periphPkg::apbDataT  prdata,
    output logic                pready,
    output logic                pslverr,
    output logic [`GPIO_W-1:0]  led,
    output logic                uartTx
);
    import periphPkg::*;

    // Register bus from the decoder
    logic                        gpioSel;
    logic                        uartSel;
    logic                        regWrite;
    logic [`PERIPH_OFFSET_W-1:0] regAddr;
    apbDataT                     regWdata;

    // Responses back to the decoder
    apbDataT                     gpioRdata;
    apbDataT                     uartRdata;
    logic                        gpioErr;
    logic                        uartErr;

    apbDecoder decoder_inst (
        .clk      (clk),
        .arstN    (arstN),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .gpioRdata(gpioRdata),
        .uartRdata(uartRdata),
        .gpioErr  (gpioErr),
        .uartErr  (uartErr),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .gpioSel  (gpioSel),
        .uartSel  (uartSel),
        .regWrite (regWrite),
        .regAddr  (regAddr),
        .regWdata (regWdata)
    );

    gpioPort gpio_inst (
        .clk  (clk),
        .arstN(arstN),
        .sel  (gpioSel),
        .write(regWrite),
        .addr (regAddr),
        .wdata(regWdata),
        .sw   (sw),
        .gpioC(gpioC),
        .rdata(gpioRdata),
        .err  (gpioErr),
        .led  (led)
    );

    uartCore uart_inst (
        .clk   (clk),
        .arstN (arstN),
        .sel   (uartSel),
        .write (regWrite),
        .addr  (regAddr),
        .wdata (regWdata),
        .uartRx(uartRx),
        .rdata (uartRdata),
        .err   (uartErr),
        .uartTx(uartTx)
    );

endmodule

// File: design/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
    parameter type entryT = logic [7:0],
    parameter int  DEPTH  = 8
) (
    input  logic  clk,
    input  logic  arstN,
    input  logic  push,
    input  entryT pushData,
    input  logic  pop,
    output entryT popData,
    output logic  full,
    output logic  empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    entryT              mem [DEPTH];
    logic [PTR_W-1:0]   wrPtr;
    logic [PTR_W-1:0]   rdPtr;
    logic [CNT_W-1:0]   count;
    logic               doPush;
    logic               doPop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Refused requests leave the state alone
    assign doPush = push & ~full;
    assign doPop  = pop & ~empty;

    // Head entry is always on the output
    assign popData = mem[rdPtr];

    // Storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Occupancy
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: design/uartCore.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module uartCore (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         sel,
    input  logic                         write,
    input  logic [`PERIPH_OFFSET_W-1:0]  addr,
    input  periphPkg::apbDataT           wdata,
    input  logic                         uartRx,
    output periphPkg::apbDataT           rdata,
    output logic                         err,
    output logic                         uartTx
);
    import periphPkg::*;

    logic [`UART_DIV_W-1:0] divQ;
    logic [`UART_DIV_W-1:0] divNext;

    // Transmit side
    uartByteT               txHead;
    logic                   txPush;
    logic                   txPop;
    logic                   txFull;
    logic                   txEmpty;
    logic                   txBusy;
    logic [9:0]             txShift;
    logic [`UART_DIV_W-1:0] txCnt;
    logic [3:0]             txBitCnt;

    // Receive side
    rxEntryT                rxHead;
    rxEntryT                rxIn;
    logic                   rxPush;
    logic                   rxPop;
    logic                   rxFull;
    logic                   rxEmpty;
    logic                   rxMeta;
    logic                   rxSync;
    logic                   rxBusy;
    logic [7:0]             rxShift;
    logic [`UART_DIV_W-1:0] rxCnt;
    logic [3:0]             rxBitCnt;

    // Register side effects at the completing edge
    assign txPush = sel & write & (addr == `UART_TXDATA) & ~txFull;
    assign rxPop  = sel & ~write & (addr == `UART_RXDATA) & ~rxEmpty;

    // Divisor below the minimum is raised to it
    assign divNext = (wdata[`UART_DIV_W-1:0] < `UART_DIV_MIN) ?
                     `UART_DIV_MIN : wdata[`UART_DIV_W-1:0];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            divQ <= `UART_DIV_RESET;
        end else if (sel && write && (addr == `UART_DIVISOR)) begin
            divQ <= divNext;
        end
    end

    // Read mux and error decode
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (addr)
            // Write into a full FIFO is dropped and flagged
            `UART_TXDATA: err = write & txFull;
            `UART_RXDATA: begin
                if (!rxEmpty) begin
                    rdata = {1'b1, {(`PERIPH_DATA_W - 10){1'b0}}, rxHead.frameErr, rxHead.data};
                end
            end
            `UART_STATUS: begin
                rdata[4:0] = {txBusy, rxFull, rxEmpty, txEmpty, txFull};
            end
            `UART_DIVISOR: rdata[`UART_DIV_W-1:0] = divQ;
            default: err = 1'b1;
        endcase
    end

    syncFifo #(
        .entryT(uartByteT),
        .DEPTH (`UART_FIFO_DEPTH)
    ) txFifo_inst (
        .clk     (clk),
        .arstN   (arstN),
        .push    (txPush),
        .pushData(wdata[7:0]),
        .pop     (txPop),
        .popData (txHead),
        .full    (txFull),
        .empty   (txEmpty)
    );

    // Idle transmitter takes the next byte
    assign txPop = ~txBusy & ~txEmpty;

    // Frame is start, eight data bits LSB first, stop
    // Ones shift in behind so the line idles high
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            txShift  <= '1;
            txBusy   <= 1'b0;
            txCnt    <= '0;
            txBitCnt <= '0;
        end else if (!txBusy) begin
            if (!txEmpty) begin
                txShift  <= {1'b1, txHead, 1'b0};
                txBusy   <= 1'b1;
                txCnt    <= divQ - 1'b1;
                txBitCnt <= '0;
            end
        end else if (txCnt == '0) begin
            txShift <= {1'b1, txShift[9:1]};
            txCnt   <= divQ - 1'b1;
            // Stop bit done
            if (txBitCnt == 4'd9) begin
                txBusy <= 1'b0;
            end else begin
                txBitCnt <= txBitCnt + 1'b1;
            end
        end else begin
            txCnt <= txCnt - 1'b1;
        end
    end

    assign uartTx = txShift[0];

    // Line synchronizer, idle level is high
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
        end else begin
            rxMeta <= uartRx;
            rxSync <= rxMeta;
        end
    end

    // Receiver
    // Half a bit to the middle of start, then a full bit per sample
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rxBusy   <= 1'b0;
            rxCnt    <= '0;
            rxBitCnt <= '0;
            rxShift  <= '0;
        end else if (!rxBusy) begin
            if (!rxSync) begin
                rxBusy   <= 1'b1;
                rxCnt    <= (divQ >> 1) - 1'b1;
                rxBitCnt <= '0;
            end
        end else if (rxCnt == '0) begin
            rxCnt    <= divQ - 1'b1;
            rxBitCnt <= rxBitCnt + 1'b1;
            if (rxBitCnt == 4'd0) begin
                // Start bit gone high again means a glitch
                if (rxSync) begin
                    rxBusy <= 1'b0;
                end
            end else if (rxBitCnt == 4'd9) begin
                rxBusy <= 1'b0;
            end else begin
                rxShift <= {rxSync, rxShift[7:1]};
            end
        end else begin
            rxCnt <= rxCnt - 1'b1;
        end
    end

    // Entry pushed at the middle of the stop bit
    assign rxPush        = rxBusy & (rxCnt == '0) & (rxBitCnt == 4'd9);
    assign rxIn.data     = rxShift;
    assign rxIn.frameErr = ~rxSync;

    // A full FIFO drops the new entry
    syncFifo #(
        .entryT(rxEntryT),
        .DEPTH (`UART_FIFO_DEPTH)
    ) rxFifo_inst (
        .clk     (clk),
        .arstN   (arstN),
        .push    (rxPush),
        .pushData(rxIn),
        .pop     (rxPop),
        .popData (rxHead),
        .full    (rxFull),
        .empty   (rxEmpty)
    );

endmodule

// File: include/periph_defs.svh
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Bus widths
`define PERIPH_ADDR_W 12
`define PERIPH_DATA_W 32
// Low address bits that select a register inside a region
`define PERIPH_OFFSET_W 8

// GPIO port width
`define GPIO_W 16
`define GPIO_LED_RESET 16'h0000

// UART sizing
`define UART_FIFO_DEPTH 8
`define UART_DIV_W 16
`define UART_DIV_RESET 16'd16
`define UART_DIV_MIN 16'd4

// Region bases
`define GPIO_BASE 12'h000
`define UART_BASE 12'h100

// GPIO register offsets
`define GPIO_DATA_A 8'h00
`define GPIO_IN_B 8'h04
`define GPIO_IN_C 8'h08
`define GPIO_EDGE_C 8'h0C

// UART register offsets
`define UART_TXDATA 8'h00
`define UART_RXDATA 8'h04
`define UART_STATUS 8'h08
`define UART_DIVISOR 8'h0C

`endif

// File: list.f
+incdir+include
design/periphPkg.sv
design/syncFifo.sv
design/apbDecoder.sv
design/gpioPort.sv
design/uartCore.sv
design/periphSoc.sv
tb/periphSoc_chk.sv
tb/periphSoc_tb.sv

// File: tb/periphSoc_chk.sv
`timescale 1ns/1ps

module periphSoc_chk (
    input logic               clk,
    input logic               arstN,
    input logic               psel,
    input logic               penable,
    input logic               pwrite,
    input logic               pready,
    input logic               pslverr,
    input periphPkg::apbDataT prdata,
    input logic               uartTx,
    input logic               txBusy
);

    // Failures seen by the testbench summary
    int failCount = 0;

    // Completion only inside an access phase
    readyInAccess: assert property (@(posedge clk) disable iff (!arstN)
        pready |-> psel && penable)
    else begin
        $error("pready high outside an access phase");
        failCount++;
    end

    // Error response only on a completing access cycle
    errWithReady: assert property (@(posedge clk) disable iff (!arstN)
        pslverr |-> pready && psel && penable)
    else begin
        $error("pslverr high outside a completing access cycle");
        failCount++;
    end

    // Line idles high between frames
    txIdleHigh: assert property (@(posedge clk) disable iff (!arstN)
        !txBusy |-> uartTx)
    else begin
        $error("uartTx low while the transmitter is idle");
        failCount++;
    end

    readDataKnown: assert property (@(posedge clk) disable iff (!arstN)
        pready && !pwrite |-> !$isunknown(prdata))
    else begin
        $error("prdata unknown on a completing read");
        failCount++;
    end

endmodule

bind periphSoc periphSoc_chk chk_inst (
    .clk    (clk),
    .arstN  (arstN),
    .psel   (psel),
    .penable(penable),
    .pwrite (pwrite),
    .pready (pready),
    .pslverr(pslverr),
    .prdata (prdata),
    .uartTx (uartTx),
    .txBusy (uart_inst.txBusy)
);

// File: tb/periphSoc_tb.sv
`timescale 1ns/1ps
`include "periph_defs.svh"

module periphSoc_tb;
    import periphPkg::*;

    localparam int GPIO_ITERS  = 16;
    localparam int UART_ROUNDS = 3;
    localparam int ROUND_BYTES = 5;
    localparam int MAX_DIV     = 12;
    localparam int BURST_BYTES = `UART_FIFO_DEPTH + 4;
    // Status polls that fit in eleven slow frames
    localparam int POLL_LIMIT  = 11 * 10 * MAX_DIV / 3;
    // Every operation may take eleven frames at the slowest divisor
    localparam int NUM_OPS     = 4 * GPIO_ITERS + UART_ROUNDS * ROUND_BYTES + BURST_BYTES + 20;
    localparam int CYCLE_LIMIT = NUM_OPS * 11 * 10 * MAX_DIV + 500;

    // Register addresses
    localparam apbAddrT ledAddr  = `GPIO_BASE + `GPIO_DATA_A;
    localparam apbAddrT swAddr   = `GPIO_BASE + `GPIO_IN_B;
    localparam apbAddrT btnAddr  = `GPIO_BASE + `GPIO_IN_C;
    localparam apbAddrT edgeAddr = `GPIO_BASE + `GPIO_EDGE_C;
    localparam apbAddrT txAddr   = `UART_BASE + `UART_TXDATA;
    localparam apbAddrT rxAddr   = `UART_BASE + `UART_RXDATA;
    localparam apbAddrT statAddr = `UART_BASE + `UART_STATUS;
    localparam apbAddrT divAddr  = `UART_BASE + `UART_DIVISOR;

    logic               clk;
    logic               arstN;
    logic               psel;
    logic               penable;
    logic               pwrite;
    apbAddrT            paddr;
    apbDataT            pwdata;
    apbDataT            prdata;
    logic               pready;
    logic               pslverr;
    logic [`GPIO_W-1:0] sw;
    logic [`GPIO_W-1:0] gpioC;
    logic [`GPIO_W-1:0] led;
    // Serial loopback
    wire                serialLine;

    integer seed = 32'h26265210;
    int     cycleCount;
    int     dataErrors;
    int     flagErrors;
    int     ledErrors;
    int     otherErrors;

    // Reference model
    logic [`GPIO_W-1:0]     ledModel;
    logic [`GPIO_W-1:0]     edgeModel;
    logic [`UART_DIV_W-1:0] divModel;
    uartByteT               rxQ[$];

    periphSoc periphSoc_inst (
        .clk    (clk),
        .arstN  (arstN),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .sw     (sw),
        .gpioC  (gpioC),
        .uartRx (serialLine),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .led    (led),
        .uartTx (serialLine)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle budget
    initial begin
        cycleCount = 0;
        forever begin
            @(posedge clk);
            cycleCount++;
            if (cycleCount >= CYCLE_LIMIT) begin
                $display("Run stopped after %0d cycles without finishing", cycleCount);
                $display("TESTBENCH FAILED");
                $finish;
            end
        end
    end

    task automatic checkData(input string name, input apbDataT got, input apbDataT exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            dataErrors++;
        end
    endtask

    task automatic checkErr(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            flagErrors++;
        end
    endtask

    task automatic checkLed(input logic [`GPIO_W-1:0] got, input logic [`GPIO_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH led got %h expected %h", got, exp);
            ledErrors++;
        end
    endtask

    // Setup cycle, then access until pready
    // Response sampled mid-cycle before the completing edge
    task automatic apbTransfer(input apbAddrT addr, input logic wr, input apbDataT data,
                               output apbDataT rd, output logic err);
        int waitCnt;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        waitCnt = 0;
        while (!pready && waitCnt < 16) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!pready) begin
            $display("pready never rose for the access to address %h", addr);
            otherErrors++;
        end
        rd  = prdata;
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input apbAddrT addr, input apbDataT data, output logic err);
        apbDataT unused;
        apbTransfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apbRead(input apbAddrT addr, output apbDataT rd, output logic err);
        apbTransfer(addr, 1'b0, '0, rd, err);
    endtask

    task automatic readExpect(input apbAddrT addr, input string name,
                              input apbDataT expData, input logic expErr);
        apbDataT rd;
        logic    err;
        apbRead(addr, rd, err);
        checkData(name, rd, expData);
        checkErr({name, " pslverr"}, err, expErr);
    endtask

    task automatic writeExpect(input apbAddrT addr, input apbDataT data,
                               input string name, input logic expErr);
        logic err;
        apbWrite(addr, data, err);
        checkErr(name, err, expErr);
    endtask

    // Poll UART status until the masked bits match
    task automatic waitStatus(input apbDataT mask, input apbDataT value);
        apbDataT st;
        logic    err;
        int      polls;
        polls = 0;
        apbRead(statAddr, st, err);
        while ((st & mask) != value && polls < POLL_LIMIT) begin
            apbRead(statAddr, st, err);
            polls++;
        end
        if ((st & mask) != value) begin
            $display("UART status %h never matched %h under mask %h", st, value, mask);
            otherErrors++;
        end
    endtask

    // Pop every expected byte as it arrives, then wait for an idle transmitter
    task automatic drainRx();
        uartByteT exp;
        while (rxQ.size() > 0) begin
            exp = rxQ.pop_front();
            waitStatus(32'h04, 32'h00);
            readExpect(rxAddr, "rx entry", 32'h8000_0000 | apbDataT'(exp), 1'b0);
        end
        waitStatus(32'h13, 32'h02);
    endtask

    initial begin
        uartByteT    b;
        logic        err;
        logic [3:0]  region;
        int unsigned rnd;
        logic [`GPIO_W-1:0] newC;
        logic [`GPIO_W-1:0] mask;

        dataErrors  = 0;
        flagErrors  = 0;
        ledErrors   = 0;
        otherErrors = 0;
        ledModel    = `GPIO_LED_RESET;
        edgeModel   = '0;
        divModel    = `UART_DIV_RESET;
        arstN       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        sw          = '0;
        gpioC       = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // Reset values, both FIFOs empty
        readExpect(ledAddr, "led reg", apbDataT'(ledModel), 1'b0);
        readExpect(edgeAddr, "edge reg", '0, 1'b0);
        readExpect(statAddr, "status", 32'h06, 1'b0);
        readExpect(divAddr, "divisor", apbDataT'(divModel), 1'b0);
        checkLed(led, ledModel);

        // GPIO traffic
        for (int i = 0; i < GPIO_ITERS; i++) begin
            ledModel = $random(seed);
            writeExpect(ledAddr, apbDataT'(ledModel), "led write pslverr", 1'b0);
            readExpect(ledAddr, "led reg", apbDataT'(ledModel), 1'b0);
            checkLed(led, ledModel);
            newC = $random(seed);
            @(negedge clk);
            sw = $random(seed);
            // Rising bits of port C stick until cleared
            edgeModel = edgeModel | (newC & ~gpioC);
            gpioC = newC;
            repeat (3) @(negedge clk);
            readExpect(swAddr, "sw", apbDataT'(sw), 1'b0);
            readExpect(btnAddr, "gpioC", apbDataT'(gpioC), 1'b0);
            readExpect(edgeAddr, "edge reg", apbDataT'(edgeModel), 1'b0);
            mask = $random(seed);
            writeExpect(edgeAddr, apbDataT'(mask), "edge clear pslverr", 1'b0);
            edgeModel = edgeModel & ~mask;
            readExpect(edgeAddr, "edge reg after clear", apbDataT'(edgeModel), 1'b0);
        end

        // Loopback at random divisors
        for (int r = 0; r < UART_ROUNDS; r++) begin
            rnd = $random(seed);
            divModel = 4 + (rnd % 9);
            writeExpect(divAddr, apbDataT'(divModel), "divisor write pslverr", 1'b0);
            readExpect(divAddr, "divisor", apbDataT'(divModel), 1'b0);
            for (int i = 0; i < ROUND_BYTES; i++) begin
                b = $random(seed);
                rxQ.push_back(b);
                writeExpect(txAddr, apbDataT'(b), "tx write pslverr", 1'b0);
            end
            drainRx();
        end

        // Overflow burst
        // Shifter takes the first byte, the FIFO holds the next DEPTH
        divModel = MAX_DIV;
        writeExpect(divAddr, apbDataT'(divModel), "divisor write pslverr", 1'b0);
        for (int i = 0; i < BURST_BYTES; i++) begin
            b = $random(seed);
            apbWrite(txAddr, apbDataT'(b), err);
            checkErr("tx burst pslverr", err, i > `UART_FIFO_DEPTH);
            if (i <= `UART_FIFO_DEPTH) begin
                rxQ.push_back(b);
            end
        end
        // Full, busy, nothing received yet
        readExpect(statAddr, "status after burst", 32'h15, 1'b0);
        drainRx();

        // Unmapped regions
        for (int i = 0; i < 4; i++) begin
            rnd    = $random(seed);
            region = 4'(2 + (rnd % 14));
            rnd    = $random(seed);
            readExpect({region, rnd[7:0]}, "unmapped read", '0, 1'b1);
            writeExpect({region, rnd[15:8]}, apbDataT'(rnd), "unmapped write pslverr", 1'b1);
        end
        // Unknown offsets and read-only targets
        readExpect(`GPIO_BASE + 8'h10, "gpio unknown offset", '0, 1'b1);
        readExpect(`UART_BASE + 8'h20, "uart unknown offset", '0, 1'b1);
        writeExpect(swAddr, 32'hFFFF, "sw write pslverr", 1'b1);
        writeExpect(btnAddr, 32'hFFFF, "gpioC write pslverr", 1'b1);
        readExpect(ledAddr, "led reg", apbDataT'(ledModel), 1'b0);
        // Empty receive FIFO reads with valid clear
        readExpect(rxAddr, "empty rx", '0, 1'b0);

        repeat (4) @(negedge clk);
        otherErrors = otherErrors + periphSoc_inst.chk_inst.failCount;
        $display("Errors: data %0d, pslverr %0d, led %0d, other %0d",
                 dataErrors, flagErrors, ledErrors, otherErrors);
        if (dataErrors + flagErrors + ledErrors + otherErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
